// File: common/i2c_host_if.sv
interface i2c_host_if;

  // Command stream
  logic [6:0] cmd_addr;
  logic       cmd_read;
  logic       cmd_write;
  logic       cmd_stop;
  logic       cmd_valid;
  logic       cmd_ready;

  // Write bytes
  logic [7:0] wr_data;
  logic       wr_valid;
  logic       wr_ready;

  // Read bytes, always accepted
  logic [7:0] rd_data;
  logic       rd_valid;

  logic       busy;
  logic       missed_ack;

  modport seq (
    output cmd_addr, cmd_read, cmd_write, cmd_stop, cmd_valid, wr_data, wr_valid,
    input  cmd_ready, wr_ready, rd_data, rd_valid, busy, missed_ack
  );

  modport mst (
    input  cmd_addr, cmd_read, cmd_write, cmd_stop, cmd_valid, wr_data, wr_valid,
    output cmd_ready, wr_ready, rd_data, rd_valid, busy, missed_ack
  );

endinterface

// File: common/i2c_seq_defs.svh
`ifndef I2C_SEQ_DEFS_SVH
`define I2C_SEQ_DEFS_SVH

// Host command addresses
`define I2C_CMDADDR_BUS1 6'h3c
`define I2C_CMDADDR_BUS2 6'h3d
`define I2C_CMDADDR_FILT 6'h00

`define I2C_OPCODE       7'h03  // Opcode field of a bus command

// Filter board port expander
`define I2C_EXP_ADDR     7'h20
`define I2C_EXP_REG      8'h0a  // Output latch register

`define I2C_PRESCALE     2      // Clocks per quarter SCL bit

`endif

// File: common/i2c_seq_pkg.sv
package i2c_seq_pkg;

  typedef enum logic [3:0] {
    ST_IDLE       = 4'h0,
    ST_CMDADDR    = 4'h1,
    ST_WR_DATA0   = 4'h2,
    ST_WR_DATA1   = 4'h3,
    ST_FCMDADDR   = 4'h4,
    ST_WR_FDATA0  = 4'h5,
    ST_WR_FDATA1  = 4'h6,
    ST_WR_FDATA2  = 4'h7,
    ST_RD_CMDADDR = 4'h8,
    ST_RD_PTR     = 4'h9,
    ST_RD_CMD     = 4'ha,
    ST_RD_DATA0   = 4'hb,
    ST_RD_DATA1   = 4'hc,
    ST_RD_DATA2   = 4'hd,
    ST_RD_DATA3   = 4'he
  } seq_state_t;

  typedef struct packed {
    logic [6:0] opcode;
    logic       rd;
    logic       spare;
    logic [6:0] dev_addr;
    logic [7:0] data0;  // Register pointer
    logic [7:0] data1;
  } cmd_word_t;

  typedef struct packed {
    logic       ant;  // Lands on GP7 of the expander
    logic [6:0] sel;
  } filt_cfg_t;

  typedef logic [3:0][7:0] resp_word_t;  // Byte 0 is the first one received

endpackage

// File: design/i2c_bus_top.sv
module i2c_bus_top
  import i2c_seq_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic [5:0]  cmd_addr_i,
  input  logic [31:0] cmd_data_i,
  input  logic        cmd_rqst_i,
  output logic        cmd_ack_o,
  output resp_word_t  cmd_resp_data_o,
  output logic        read_done_o,
  output logic        en_i2c2_o,
  output logic        ready_o,
  output logic        missed_ack_o,
  input  logic        scl_i,
  output logic        scl_o,
  output logic        scl_t_o,
  input  logic        sda_i,
  output logic        sda_o,
  output logic        sda_t_o
);

  i2c_host_if host_if ();

  cmd_word_t cmd_word;
  filt_cfg_t filt_cfg;
  logic      filt_change;
  logic      filt_load;

  assign cmd_word     = cmd_data_i;
  assign filt_cfg.sel = cmd_data_i[23:17];
  assign filt_cfg.ant = cmd_data_i[13];  // Rx antenna option
  assign missed_ack_o = host_if.missed_ack;

  i2c_shadow_regs i2c_shadow_regs_inst (
    .clk           (clk),
    .rst           (rst),
    .filt_cfg_i    (filt_cfg),
    .filt_load_i   (filt_load),
    .filt_change_o (filt_change)
  );

  i2c_cmd_seq i2c_cmd_seq_inst (
    .clk           (clk),
    .rst           (rst),
    .cmd_addr_i    (cmd_addr_i),
    .cmd_data_i    (cmd_word),
    .cmd_rqst_i    (cmd_rqst_i),
    .filt_change_i (filt_change),
    .filt_cfg_i    (filt_cfg),
    .filt_load_o   (filt_load),
    .cmd_ack_o     (cmd_ack_o),
    .resp_o        (cmd_resp_data_o),
    .read_done_o   (read_done_o),
    .en_i2c2_o     (en_i2c2_o),
    .ready_o       (ready_o),
    .host          (host_if.seq)
  );

  i2c_master i2c_master_inst (
    .clk     (clk),
    .rst     (rst),
    .host    (host_if.mst),
    .scl_i   (scl_i),
    .scl_o   (scl_o),
    .scl_t_o (scl_t_o),
    .sda_i   (sda_i),
    .sda_o   (sda_o),
    .sda_t_o (sda_t_o)
  );

endmodule

// File: design/i2c_shadow_regs.sv
module i2c_shadow_regs
  import i2c_seq_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  filt_cfg_t filt_cfg_i,
  input  logic      filt_load_i,
  output logic      filt_change_o
);

  filt_cfg_t filt_q;  // Last field sent to the expander
  logic      sel_diff;
  logic      ant_diff;

  always_ff @(posedge clk) begin
    if (rst) begin
      filt_q <= '0;
    end else if (filt_load_i) begin
      filt_q <= filt_cfg_i;
    end
  end

  // Either field moving needs a new expander write
  assign sel_diff = (filt_cfg_i.sel != filt_q.sel);
  assign ant_diff = (filt_cfg_i.ant != filt_q.ant);

  assign filt_change_o = sel_diff || ant_diff;

endmodule

// File: filelist.f
+incdir+common
common/i2c_seq_pkg.sv
common/i2c_host_if.sv
i2c_master/i2c_master.sv
i2c_cmd_seq/i2c_cmd_seq.sv
design/i2c_shadow_regs.sv
design/i2c_bus_top.sv
tests/i2c_slave_model.sv
tests/tb_i2c_bus.sv

// File: i2c_cmd_seq/i2c_cmd_seq.sv
`include "i2c_seq_defs.svh"

module i2c_cmd_seq
  import i2c_seq_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic [5:0] cmd_addr_i,
  input  cmd_word_t  cmd_data_i,
  input  logic       cmd_rqst_i,
  input  logic       filt_change_i,
  input  filt_cfg_t  filt_cfg_i,
  output logic       filt_load_o,
  output logic       cmd_ack_o,
  output resp_word_t resp_o,
  output logic       read_done_o,
  output logic       en_i2c2_o,
  output logic       ready_o,
  i2c_host_if.seq    host
);

  seq_state_t state, state_d;
  logic [6:0] dev_q;
  logic [7:0] data0_q;
  logic [7:0] data1_q;
  resp_word_t resp_q;
  logic       cmd_ack_q;
  logic       en_i2c2_q;
  logic       bus_cmd, filt_cmd, seq_free;
  logic       start_bus, start_filt, rejected, rd_busy_d;

  assign bus_cmd  = (cmd_addr_i == `I2C_CMDADDR_BUS1 || cmd_addr_i == `I2C_CMDADDR_BUS2) &&
                    cmd_data_i.opcode == `I2C_OPCODE;
  assign filt_cmd = (cmd_addr_i == `I2C_CMDADDR_FILT) && filt_change_i;
  assign seq_free = (state == ST_IDLE) && !host.busy;

  assign start_bus  = cmd_rqst_i && bus_cmd && seq_free;
  assign start_filt = cmd_rqst_i && filt_cmd && seq_free;
  assign rejected   = cmd_rqst_i && (bus_cmd || filt_cmd) && !seq_free;  // No queue
  assign rd_busy_d  = state_d inside {ST_RD_CMDADDR, ST_RD_PTR, ST_RD_CMD, ST_RD_DATA0,
                                      ST_RD_DATA1, ST_RD_DATA2, ST_RD_DATA3};

  assign ready_o     = seq_free;
  assign filt_load_o = start_filt;
  assign cmd_ack_o   = cmd_ack_q;
  assign en_i2c2_o   = en_i2c2_q;
  assign resp_o      = resp_q;

  always_comb begin
    state_d        = state;
    host.cmd_addr  = dev_q;
    host.cmd_valid = 1'b0;
    host.cmd_write = 1'b0;
    host.cmd_read  = 1'b0;
    host.cmd_stop  = 1'b0;
    host.wr_data   = data0_q;
    host.wr_valid  = 1'b0;
    read_done_o    = 1'b0;
    case (state)
      ST_IDLE: begin
        if (start_bus) state_d = cmd_data_i.rd ? ST_RD_CMDADDR : ST_CMDADDR;
        else if (start_filt) state_d = ST_FCMDADDR;
      end
      ST_CMDADDR, ST_FCMDADDR: begin
        host.cmd_valid = 1'b1;
        host.cmd_write = 1'b1;
        if (host.cmd_ready) state_d = (state == ST_CMDADDR) ? ST_WR_DATA0 : ST_WR_FDATA0;
      end
      ST_WR_DATA0, ST_WR_FDATA0: begin
        host.cmd_write = 1'b1;
        host.wr_valid  = 1'b1;
        if (host.wr_ready) state_d = (state == ST_WR_DATA0) ? ST_WR_DATA1 : ST_WR_FDATA1;
      end
      ST_WR_DATA1: begin
        host.cmd_write = 1'b1;
        host.cmd_stop  = 1'b1;
        host.wr_valid  = 1'b1;
        host.wr_data   = data1_q;
        if (host.wr_ready) state_d = ST_IDLE;
      end
      ST_WR_FDATA1: begin
        host.cmd_write = 1'b1;
        host.wr_valid  = 1'b1;
        host.wr_data   = data1_q;
        if (host.wr_ready) state_d = ST_WR_FDATA2;
      end
      ST_WR_FDATA2: begin
        host.cmd_write = 1'b1;
        host.cmd_stop  = 1'b1;
        host.wr_valid  = 1'b1;
        host.wr_data   = 8'h00;
        if (host.wr_ready) state_d = ST_IDLE;
      end
      ST_RD_CMDADDR: begin
        host.cmd_valid = 1'b1;
        host.cmd_write = 1'b1;
        host.cmd_stop  = 1'b1;
        if (host.cmd_ready) state_d = ST_RD_PTR;
      end
      ST_RD_PTR: begin
        host.cmd_write = 1'b1;
        host.cmd_stop  = 1'b1;
        host.wr_valid  = 1'b1;  // Register pointer
        if (host.wr_ready) state_d = ST_RD_CMD;
      end
      ST_RD_CMD: begin
        host.cmd_valid = 1'b1;
        host.cmd_read  = 1'b1;
        if (host.cmd_ready) state_d = ST_RD_DATA0;
      end
      ST_RD_DATA0, ST_RD_DATA1, ST_RD_DATA2: begin
        host.cmd_read = 1'b1;
        if (host.rd_valid) state_d = seq_state_t'(state + 4'h1);
      end
      ST_RD_DATA3: begin
        host.cmd_read = 1'b1;
        host.cmd_stop = 1'b1;  // Master NACKs this byte
        if (host.rd_valid) begin
          read_done_o = 1'b1;
          state_d     = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ST_IDLE;
      cmd_ack_q <= 1'b0;
      en_i2c2_q <= 1'b0;
      resp_q    <= '0;
    end else begin
      state     <= state_d;
      cmd_ack_q <= !rejected && !rd_busy_d;
      if (start_bus) en_i2c2_q <= (cmd_addr_i == `I2C_CMDADDR_BUS2);
      else if (start_filt) en_i2c2_q <= 1'b1;
      if (host.rd_valid) begin
        case (state)
          ST_RD_DATA0: resp_q[0] <= host.rd_data;
          ST_RD_DATA1: resp_q[1] <= host.rd_data;
          ST_RD_DATA2: resp_q[2] <= host.rd_data;
          ST_RD_DATA3: resp_q[3] <= host.rd_data;
          default: ;
        endcase
      end
    end
  end

  // Transaction payload
  always_ff @(posedge clk) begin
    if (start_bus) begin
      dev_q   <= cmd_data_i.dev_addr;
      data0_q <= cmd_data_i.data0;
      data1_q <= cmd_data_i.data1;
    end else if (start_filt) begin
      dev_q   <= `I2C_EXP_ADDR;
      data0_q <= `I2C_EXP_REG;
      data1_q <= filt_cfg_i;  // Antenna in bit 7
    end
  end

endmodule

// File: i2c_master/i2c_master.sv
`include "i2c_seq_defs.svh"

module i2c_master (
  input  logic    clk,
  input  logic    rst,
  i2c_host_if.mst host,
  input  logic    scl_i,
  output logic    scl_o,
  output logic    scl_t_o,
  input  logic    sda_i,
  output logic    sda_o,
  output logic    sda_t_o
);

  localparam int PRESC = `I2C_PRESCALE;
  localparam int PW = $clog2(PRESC + 1);
  localparam logic [PW-1:0] PRESC_LOAD = PW'(PRESC - 1);

  typedef enum logic [2:0] {
    M_IDLE, M_START, M_ADDR, M_WAIT, M_WRITE, M_READ, M_STOP, M_DROP
  } mst_state_t;

  mst_state_t    state;
  logic [PW-1:0] presc_cnt;
  logic [1:0]    qtr;      // Quarter of the current bit slot
  logic [3:0]    bit_idx;  // 8 is the ACK slot
  logic [7:0]    shreg;
  logic          rd_q;
  logic          stop_q;
  logic          drop_q;
  logic          ack_q;    // High means NACK
  logic          scl_rel;
  logic          sda_rel;
  logic          slot_active;
  logic          tx_state;
  logic          scl_hold;
  logic          tick;
  logic          end_of_slot;
  logic          cmd_take;
  logic          wr_take;

  assign slot_active = state inside {M_START, M_ADDR, M_WRITE, M_READ, M_STOP};
  assign tx_state    = state inside {M_ADDR, M_WRITE};
  assign scl_hold    = (qtr == 2'd1) && scl_rel && !scl_i;  // Target stretching
  assign tick        = slot_active && (presc_cnt == '0) && !scl_hold;
  assign end_of_slot = tick && (qtr == 2'd3);

  assign host.cmd_ready  = (state == M_IDLE);
  assign host.wr_ready   = (state == M_WAIT) || (state == M_DROP && !rd_q);
  assign host.rd_data    = shreg;
  assign host.rd_valid   = (state == M_READ && end_of_slot && bit_idx == 4'd7) ||
                           (state == M_DROP && rd_q);
  assign host.busy       = slot_active || (state == M_WAIT);
  assign host.missed_ack = tx_state && end_of_slot && bit_idx == 4'd8 && ack_q;

  assign cmd_take = host.cmd_valid && host.cmd_ready;
  assign wr_take  = host.wr_valid && host.wr_ready;

  // Line levels per quarter
  always_comb begin
    scl_rel = 1'b1;
    sda_rel = 1'b1;
    case (state)
      M_START: begin
        scl_rel = (qtr != 2'd3);
        sda_rel = (qtr < 2'd2);  // SDA falls while SCL is high
      end
      M_ADDR, M_WRITE: begin
        scl_rel = (qtr == 2'd1) || (qtr == 2'd2);
        sda_rel = (bit_idx == 4'd8) ? 1'b1 : shreg[7];
      end
      M_READ: begin
        scl_rel = (qtr == 2'd1) || (qtr == 2'd2);
        sda_rel = (bit_idx == 4'd8) ? stop_q : 1'b1;  // NACK the last byte
      end
      M_STOP: begin
        scl_rel = (qtr != 2'd0);
        sda_rel = (qtr == 2'd3);
      end
      M_WAIT:  scl_rel = 1'b0;  // Hold the bus between bytes
      default: ;
    endcase
  end

  assign scl_o   = 1'b0;
  assign sda_o   = 1'b0;
  assign scl_t_o = scl_rel;
  assign sda_t_o = sda_rel;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= M_IDLE;
      presc_cnt <= PRESC_LOAD;
      qtr       <= '0;
      bit_idx   <= '0;
      rd_q      <= 1'b0;
      stop_q    <= 1'b0;
      drop_q    <= 1'b0;
      ack_q     <= 1'b0;
    end else begin
      if (tick) begin
        presc_cnt <= PRESC_LOAD;
        qtr       <= qtr + 2'd1;
      end else if (slot_active && presc_cnt != '0) begin
        presc_cnt <= presc_cnt - 1'b1;
      end
      if (tick && qtr == 2'd1) ack_q <= sda_i;

      case (state)
        M_IDLE: begin
          if (cmd_take && (host.cmd_read || host.cmd_write)) begin
            rd_q  <= host.cmd_read;
            state <= M_START;
          end
        end
        M_START: begin
          if (end_of_slot) begin
            bit_idx <= '0;
            state   <= M_ADDR;
          end
        end
        M_ADDR, M_WRITE: begin
          if (end_of_slot) begin
            if (bit_idx != 4'd8) begin
              bit_idx <= bit_idx + 4'd1;
            end else if (ack_q) begin
              drop_q <= !(state == M_WRITE && stop_q);
              state  <= M_STOP;
            end else if (state == M_WRITE && stop_q) begin
              state <= M_STOP;
            end else if (state == M_ADDR && rd_q) begin
              bit_idx <= '0;
              state   <= M_READ;
            end else begin
              state <= M_WAIT;
            end
          end
        end
        M_WAIT: begin
          if (wr_take) begin
            stop_q  <= host.cmd_stop;
            bit_idx <= '0;
            state   <= M_WRITE;
          end
        end
        M_READ: begin
          if (end_of_slot) begin
            if (bit_idx == 4'd7) stop_q <= host.cmd_stop;
            if (bit_idx != 4'd8) begin
              bit_idx <= bit_idx + 4'd1;
            end else if (stop_q) begin
              state <= M_STOP;
            end else begin
              bit_idx <= '0;
            end
          end
        end
        M_STOP: begin
          if (end_of_slot) begin
            drop_q <= 1'b0;
            state  <= drop_q ? M_DROP : M_IDLE;
          end
        end
        M_DROP: begin
          // Swallow what is left of the command up to its stop
          if (host.cmd_stop && (rd_q || wr_take)) state <= M_IDLE;
        end
        default: state <= M_IDLE;
      endcase
    end
  end

  // Shift register
  always_ff @(posedge clk) begin
    if (cmd_take) begin
      shreg <= {host.cmd_addr, host.cmd_read};
    end else if (wr_take) begin
      shreg <= host.wr_data;
    end else if (tx_state && end_of_slot && bit_idx != 4'd8) begin
      shreg <= {shreg[6:0], 1'b1};
    end else if (state == M_READ && tick && qtr == 2'd1 && bit_idx != 4'd8) begin
      shreg <= {shreg[6:0], sda_i};  // MSB first
    end else if (host.missed_ack) begin
      shreg <= 8'hff;  // Filler for dropped read bytes
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f filelist.f \
  --top-module tb_i2c_bus -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

printf '%s\n' "$out" | grep -qx "STATUS: PASS" || exit 1
exit 0

// File: tests/i2c_slave_model.sv
module i2c_slave_model #(
  parameter logic [6:0] DEV_A = 7'h50,
  parameter logic [6:0] DEV_B = 7'h20
) (
  input  logic scl_i,
  input  logic sda_i,
  output logic sda_o  // Low pulls SDA down
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [7:0] regs [0:1][0:255];  // One register file per device
  logic       sda_drv = 1'b1;
  logic       scl_q = 1'b1;
  logic       sda_q = 1'b1;
  logic       active = 1'b0;
  logic       addr_phase = 1'b0;
  logic       ptr_phase = 1'b0;
  logic       selected = 1'b0;
  logic       rd_mode = 1'b0;
  logic       ack_seen = 1'b0;
  int         dev_idx = 0;
  int         bit_cnt = 0;  // SCL rising edges in the current frame
  logic [7:0] rx = '0;
  logic [7:0] tx = '0;
  logic [7:0] ptr = '0;
  int         start_cnt = 0;
  int         wr_cnt = 0;

  assign sda_o = sda_drv;

  initial begin
    for (int i = 0; i < 256; i++) begin
      regs[0][i] = 8'(i * 37 + 11) ^ 8'hc3;
      regs[1][i] = 8'(i) ^ 8'h5a;
    end
  end

  task automatic take_byte();
    if (addr_phase) begin
      addr_phase = 1'b0;
      if (rx[7:1] == DEV_A || rx[7:1] == DEV_B) begin
        selected  = 1'b1;
        dev_idx   = (rx[7:1] == DEV_B) ? 1 : 0;
        rd_mode   = rx[0];
        ptr_phase = !rx[0];
        sda_drv   = 1'b0;  // ACK
      end
    end else if (selected) begin
      if (ptr_phase) begin
        ptr       = rx;
        ptr_phase = 1'b0;
      end else begin
        regs[dev_idx][ptr] = rx;
        ptr                = ptr + 8'd1;
        wr_cnt++;
      end
      sda_drv = 1'b0;
    end
  endtask

  always @(scl_i or sda_i) begin
    if (scl_i === scl_q) begin
      if (scl_i === 1'b1 && sda_q === 1'b1 && sda_i === 1'b0) begin  // Start
        active     = 1'b1;
        addr_phase = 1'b1;
        selected   = 1'b0;
        rd_mode    = 1'b0;
        bit_cnt    = 0;
        sda_drv    = 1'b1;
        start_cnt++;
      end else if (scl_i === 1'b1 && sda_q === 1'b0 && sda_i === 1'b1) begin  // Stop
        active  = 1'b0;
        sda_drv = 1'b1;
      end
    end else if (active && scl_i === 1'b1) begin
      if (bit_cnt < 8) rx = {rx[6:0], sda_i};
      else ack_seen = (sda_i === 1'b0);
      bit_cnt++;
    end else if (active && scl_i === 1'b0) begin
      if (bit_cnt == 8) begin
        if (addr_phase || !rd_mode) take_byte();
        else sda_drv = 1'b1;  // Master ACK slot
      end else if (bit_cnt == 9) begin
        bit_cnt = 0;
        sda_drv = 1'b1;
        if (selected && rd_mode && ack_seen) begin
          tx      = regs[dev_idx][ptr];
          ptr     = ptr + 8'd1;
          sda_drv = tx[7];
        end
      end else if (bit_cnt > 0 && selected && rd_mode && !addr_phase) begin
        sda_drv = tx[7 - bit_cnt];
      end
    end
    scl_q = scl_i;
    sda_q = sda_i;
  end

endmodule

// File: tests/tb_i2c_bus.sv
`include "i2c_seq_defs.svh"

module tb_i2c_bus
  import i2c_seq_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_NS      = 20;
  localparam int NUM_TXN     = 12;
  localparam int SLOTS_TXN   = 72;  // Worst case read, two frames
  localparam int WATCHDOG_NS = NUM_TXN * SLOTS_TXN * 4 * `I2C_PRESCALE * CLK_NS * 3;
  localparam logic [6:0] SLAVE_ADDR  = 7'h50;
  localparam logic [6:0] ABSENT_ADDR = 7'h33;

  logic        clk = 1'b0;
  logic        rst;
  logic [5:0]  cmd_addr_i;
  logic [31:0] cmd_data_i;
  logic        cmd_rqst_i;
  logic        cmd_ack_o;
  logic        read_done_o;
  logic        en_i2c2_o;
  logic        ready_o;
  logic        missed_ack_o;
  resp_word_t  cmd_resp_data_o;
  logic        scl_o;
  logic        scl_t_o;
  logic        sda_o;
  logic        sda_t_o;
  logic        scl_line;
  logic        sda_line;
  logic        sda_slave;
  int          seed = 94708;
  int          done_cnt = 0;
  int          miss_cnt = 0;

  assign scl_line = scl_t_o ? 1'b1 : scl_o;  // Target never stretches
  assign sda_line = (sda_t_o ? 1'b1 : sda_o) & sda_slave;

  i2c_bus_top i2c_bus_top_inst (
    .clk (clk), .rst (rst),
    .cmd_addr_i (cmd_addr_i), .cmd_data_i (cmd_data_i), .cmd_rqst_i (cmd_rqst_i),
    .cmd_ack_o (cmd_ack_o), .cmd_resp_data_o (cmd_resp_data_o),
    .read_done_o (read_done_o), .en_i2c2_o (en_i2c2_o), .ready_o (ready_o),
    .missed_ack_o (missed_ack_o),
    .scl_i (scl_line), .scl_o (scl_o), .scl_t_o (scl_t_o),
    .sda_i (sda_line), .sda_o (sda_o), .sda_t_o (sda_t_o)
  );

  i2c_slave_model #(.DEV_A(SLAVE_ADDR), .DEV_B(`I2C_EXP_ADDR)) i2c_slave_model_inst (
    .scl_i (scl_line), .sda_i (sda_line), .sda_o (sda_slave)
  );

  always #(CLK_NS / 2) clk = ~clk;

  always @(posedge clk) begin
    if (!rst && read_done_o) done_cnt <= done_cnt + 1;
    if (!rst && missed_ack_o) miss_cnt <= miss_cnt + 1;
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_resp(input string name, input resp_word_t exp, input resp_word_t act);
    if (act !== exp)
      fail_now($sformatf("error at %0t: %s expected %h got %h", $time, name, exp, act));
  endtask

  task automatic check_bytes(input string name, input filt_cfg_t exp, input filt_cfg_t act);
    if (act !== exp)
      fail_now($sformatf("error at %0t: %s expected %h got %h", $time, name, exp, act));
  endtask

  task automatic check_reg(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp)
      fail_now($sformatf("error at %0t: %s expected %h got %h", $time, name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
      fail_now($sformatf("error at %0t: %s expected %b got %b", $time, name, exp, act));
  endtask

  // First byte read lands in the low byte
  function automatic resp_word_t expected_resp(input logic [7:0] ptr);
    resp_word_t r;
    logic [7:0] p;
    p = ptr;
    for (int k = 0; k < 4; k++) begin
      r[k] = i2c_slave_model_inst.regs[0][p];
      p    = p + 8'd1;
    end
    return r;
  endfunction

  function automatic filt_cfg_t expected_filt(input logic [31:0] w);
    filt_cfg_t f;
    f.ant = w[13];
    f.sel = w[23:17];
    return f;
  endfunction

  function automatic cmd_word_t make_cmd(input logic rd, input logic [6:0] dev,
                                         input logic [7:0] d0, input logic [7:0] d1);
    cmd_word_t c;
    c.opcode   = `I2C_OPCODE;
    c.rd       = rd;
    c.spare    = 1'b0;
    c.dev_addr = dev;
    c.data0    = d0;
    c.data1    = d1;
    return c;
  endfunction

  task automatic send_cmd(input logic [5:0] addr, input logic [31:0] data);
    @(negedge clk);
    cmd_addr_i = addr;
    cmd_data_i = data;
    cmd_rqst_i = 1'b1;
    @(negedge clk);
    cmd_rqst_i = 1'b0;
  endtask

  task automatic wait_ready();
    while (!ready_o) @(negedge clk);
  endtask

  task automatic run_read(input logic [5:0] addr, input logic [7:0] ptr);
    int done_base;
    done_base = done_cnt;
    send_cmd(addr, make_cmd(1'b1, SLAVE_ADDR, ptr, 8'h00));
    while (!read_done_o) begin
      check_bit("cmd_ack_o", 1'b0, cmd_ack_o);
      @(negedge clk);
    end
    @(negedge clk);
    check_resp("cmd_resp_data_o", expected_resp(ptr), cmd_resp_data_o);
    wait_ready();
    @(negedge clk);
    if (done_cnt != done_base + 1)
      fail_now($sformatf("read_done_o pulsed %0d times in one read", done_cnt - done_base));
  endtask

  initial begin
    #(WATCHDOG_NS);
    fail_now($sformatf("timeout: the run exceeded %0d ns", WATCHDOG_NS));
  end

  initial begin
    logic [7:0]  ptr;
    logic [7:0]  ptr_next;
    logic [7:0]  val;
    logic [7:0]  keep;
    logic [5:0]  bus_addr;
    logic [31:0] filt_raw;
    int          starts;
    int          writes;
    int          base;
    int          k;
    rst        = 1'b1;
    cmd_addr_i = '0;
    cmd_data_i = '0;
    cmd_rqst_i = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    check_bit("cmd_ack_o", 1'b0, cmd_ack_o);
    check_bit("read_done_o", 1'b0, read_done_o);
    check_bit("en_i2c2_o", 1'b0, en_i2c2_o);
    check_bit("missed_ack_o", 1'b0, missed_ack_o);
    check_bit("scl_t_o", 1'b1, scl_t_o);
    check_bit("sda_t_o", 1'b1, sda_t_o);
    check_bit("scl_o", 1'b0, scl_o);
    check_bit("sda_o", 1'b0, sda_o);
    check_resp("cmd_resp_data_o", '0, cmd_resp_data_o);
    rst = 1'b0;
    @(negedge clk);
    check_bit("cmd_ack_o", 1'b1, cmd_ack_o);

    // Register write, then readback
    ptr = 8'($random(seed));
    val = 8'($random(seed));
    if (val == i2c_slave_model_inst.regs[0][ptr]) val = ~val;  // Write must change the reg
    send_cmd(`I2C_CMDADDR_BUS1, make_cmd(1'b0, SLAVE_ADDR, ptr, val));
    check_bit("en_i2c2_o", 1'b0, en_i2c2_o);
    wait_ready();
    check_reg("slave reg", val, i2c_slave_model_inst.regs[0][ptr]);
    run_read(`I2C_CMDADDR_BUS1, ptr);

    // Expander update, then the same field again
    filt_raw     = $random(seed);
    filt_raw[17] = 1'b1;
    starts       = i2c_slave_model_inst.start_cnt;
    send_cmd(`I2C_CMDADDR_FILT, filt_raw);
    wait_ready();
    check_bit("en_i2c2_o", 1'b1, en_i2c2_o);
    check_bytes("expander reg 0x0a", expected_filt(filt_raw),
                filt_cfg_t'(i2c_slave_model_inst.regs[1][`I2C_EXP_REG]));
    check_reg("expander reg 0x0b", 8'h00, i2c_slave_model_inst.regs[1][8'h0b]);
    if (i2c_slave_model_inst.start_cnt != starts + 1)
      fail_now("the expander update was not a single bus transaction");
    starts = i2c_slave_model_inst.start_cnt;
    send_cmd(`I2C_CMDADDR_FILT, filt_raw);
    repeat (40) @(negedge clk);
    check_bit("ready_o", 1'b1, ready_o);
    if (i2c_slave_model_inst.start_cnt != starts)
      fail_now("an unchanged filter field started a bus transaction");

    for (k = 0; k < 4; k++) begin
      bus_addr = k[0] ? `I2C_CMDADDR_BUS2 : `I2C_CMDADDR_BUS1;
      ptr      = 8'($random(seed));
      run_read(bus_addr, ptr);
      check_bit("en_i2c2_o", bus_addr == `I2C_CMDADDR_BUS2, en_i2c2_o);
    end

    // Request while busy is lost
    ptr      = 8'($random(seed));
    ptr_next = ptr + 8'd1;
    val      = ~i2c_slave_model_inst.regs[0][ptr];
    keep     = i2c_slave_model_inst.regs[0][ptr_next];
    send_cmd(`I2C_CMDADDR_BUS1, make_cmd(1'b0, SLAVE_ADDR, ptr, val));
    check_bit("ready_o", 1'b0, ready_o);
    cmd_data_i = make_cmd(1'b0, SLAVE_ADDR, ptr_next, ~keep);
    cmd_rqst_i = 1'b1;
    @(negedge clk);
    check_bit("cmd_ack_o", 1'b0, cmd_ack_o);
    cmd_rqst_i = 1'b0;
    @(negedge clk);
    check_bit("cmd_ack_o", 1'b1, cmd_ack_o);
    wait_ready();
    check_reg("slave reg", val, i2c_slave_model_inst.regs[0][ptr]);
    check_reg("untouched slave reg", keep, i2c_slave_model_inst.regs[0][ptr_next]);

    // Absent device
    base   = miss_cnt;
    writes = i2c_slave_model_inst.wr_cnt;
    send_cmd(`I2C_CMDADDR_BUS1, make_cmd(1'b0, ABSENT_ADDR, 8'($random(seed)), 8'h5a));
    wait_ready();
    @(negedge clk);
    if (miss_cnt != base + 1)
      fail_now($sformatf("missed_ack_o pulsed %0d times for the absent device", miss_cnt - base));
    check_bit("scl_t_o", 1'b1, scl_t_o);
    check_bit("sda_t_o", 1'b1, sda_t_o);
    check_bit("scl_o", 1'b0, scl_o);
    check_bit("sda_o", 1'b0, sda_o);
    check_bit("ready_o", 1'b1, ready_o);
    check_bit("en_i2c2_o", 1'b0, en_i2c2_o);
    if (i2c_slave_model_inst.wr_cnt != writes)
      fail_now("a write to the absent device changed the target registers");

    $display("STATUS: PASS");
    $finish;
  end

endmodule
